//--- dv/neoB1Tb.sv
`timescale 1ns/1ps
`include "b1_params.svh"

module neoB1Tb import b1Pkg::*;
();

	logic CLK_1MB, arstN, pck1, pck2, ldX, sprWe, lineSwap, chbl, cpuAs, cpuWr;
	logic [23:0]          pbus;
	logic [`B1_COL_W-1:0] gad, fixd;
	logic [23:1]          cpuAddr;
	palAddr_t             pa;
	logic                 resetN;

	int          errCount;
	int          checkCount;
	integer      seed;
	logic [31:0] rnd;
	palAddr_t    sprLine [0:`B1_LB_DEPTH-1];  // Expected bank seen after the next swap
	logic [3:0]  fixLine [0:31];               // Per pixel fix colour
	logic        blankLine [0:31];
	logic        cpuLine [0:31];               // CPU palette access in that cycle
	logic [3:0]  gadSeq [0:5];                 // Sprite pixels to write
	logic [3:0]  fixPalModel;

	neoB1 i_dut (.*);

	initial
	begin
		CLK_1MB = 1'b0;
		forever #5 CLK_1MB = ~CLK_1MB;
	end

	task automatic nextCycle();
		@(posedge CLK_1MB);
		#1;  // Drive just after the edge
	endtask

	task automatic checkPa(input palAddr_t got, input palAddr_t exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERROR %0t pa (%s): got %h expected %h", $time, what, got, exp);
		end
	endtask

	task automatic checkReset(input logic got, input logic exp, input string what);
		checkCount++;
		if (got !== exp)
		begin
			errCount++;
			$display("ERROR %0t resetN (%s): got %b expected %b", $time, what, got, exp);
		end
	endtask

	task automatic applyReset();
		arstN = 1'b0;
		repeat (2) @(posedge CLK_1MB);
		#1 arstN = 1'b1;
	endtask

	task automatic clearModel();
		int p;
		for (p = 0; p < `B1_LB_DEPTH; p++)
			sprLine[p] = palAddr_t'(`B1_BACKDROP);
		for (p = 0; p < 32; p++)
		begin
			fixLine[p] = 4'h0;
			blankLine[p] = 1'b0;
			cpuLine[p] = 1'b0;
		end
	endtask

	// Blank wins over fix, fix over sprite or backdrop
	function automatic palAddr_t expectedPixel(input int p);
		if (blankLine[p])
			return '0;
		if (fixLine[p] != 4'h0)
			return {4'h0, fixPalModel, fixLine[p]};
		return sprLine[p];
	endfunction

	// PCK1 latch, load X, then one pixel per cycle
	task automatic writeSprite(input logic [7:0] p, input logic [7:0] x);
		logic [7:0] pos;
		int         j;
		pbus = {p, x, 8'h00};
		pck1 = 1'b1;
		nextCycle();
		pck1 = 1'b0;
		ldX = 1'b1;
		nextCycle();
		ldX = 1'b0;
		pos = x;
		for (j = 0; j < 6; j++)
		begin
			sprWe = 1'b1;
			gad = gadSeq[j];
			if (gadSeq[j] != 4'h0)
				sprLine[pos] = {p, gadSeq[j]};  // Colour 0 leaves backdrop
			pos++;
			nextCycle();
		end
		sprWe = 1'b0;
		gad = 4'h0;
	endtask

	// Swap banks and follow n pixels through to pa
	task automatic scanLine(input int n, input string what);
		int i;
		lineSwap = 1'b1;
		nextCycle();
		lineSwap = 1'b0;
		for (i = 0; i < n + 2; i++)
		begin
			fixd = (i < n) ? fixLine[i] : 4'h0;  // Sampled at edge i+1
			chbl = (i < n) ? blankLine[i] : 1'b0;
			cpuAs = (i < n) && cpuLine[i];
			cpuAddr = {`B1_CPU_PAL_HI, 9'h0, 12'h5A0 + 12'(i)};
			@(negedge CLK_1MB);
			if (cpuAs)
				checkPa(pa, palAddr_t'(12'h5A0 + 12'(i)), {what, " cpu"});
			else if (i >= 2)
				checkPa(pa, expectedPixel(i - 2), what);  // Two edges of latency
			nextCycle();
		end
		repeat (`B1_LB_DEPTH) nextCycle();  // Let clear-on-read sweep the whole bank
		clearModel();
	endtask

	task automatic renderTest();
		int j;
		for (j = 0; j < 6; j++)
		begin
			rnd = $random(seed);
			gadSeq[j] = (rnd[3:0] == 4'h0) ? 4'h1 : rnd[3:0];
		end
		writeSprite(8'h3C, 8'd10);
		scanLine(21, "render");
	endtask

	task automatic transparencyTest();
		int j;
		for (j = 0; j < 6; j++)
		begin
			rnd = $random(seed);
			gadSeq[j] = (j == 1 || j == 4) ? 4'h0 : rnd[3:0];
		end
		writeSprite(8'h81, 8'd4);
		scanLine(14, "transparent");
		scanLine(14, "other bank");
		scanLine(14, "cleared");  // Same bank again, nothing rewritten
	endtask

	task automatic fixTest();
		int p;
		pbus = 24'h090000;
		pck2 = 1'b1;
		nextCycle();
		pck2 = 1'b0;
		fixPalModel = 4'h9;
		for (p = 0; p < 6; p++)
			gadSeq[p] = 4'h7;
		writeSprite(8'h22, 8'd6);
		for (p = 0; p < 16; p++)
			fixLine[p] = (p % 2 == 1) ? p[3:0] : 4'h0;
		scanLine(16, "fix");
	endtask

	task automatic blankCpuTest();
		int p;
		for (p = 0; p < 6; p++)
			gadSeq[p] = 4'hC;
		writeSprite(8'h5E, 8'd2);
		for (p = 3; p < 13; p++)
			blankLine[p] = 1'b1;
		for (p = 8; p < 11; p++)
			cpuLine[p] = 1'b1;  // Inside blanking
		cpuLine[15] = 1'b1;
		scanLine(18, "blank");
	endtask

	task automatic watchdogTest();
		int i;
		int lag;
		applyReset();
		cpuWr = 1'b1;
		for (i = 0; i < 400; i++)
		begin
			cpuAs = (i % 64 == 0);
			cpuAddr = {2'b00, `B1_WD_KICK_HI, 16'h0};
			lineSwap = (i % 50 == 25);  // Would release an expired watchdog
			@(negedge CLK_1MB);
			checkReset(resetN, 1'b1, "kicked");
			nextCycle();
		end
		for (i = 0; i < `B1_WD_LIMIT + 20; i++)
		begin
			cpuAs = (i % 32 == 0);
			cpuAddr = {2'b00, 5'b00011, 16'h0};  // Write elsewhere, not a kick
			@(negedge CLK_1MB);
			checkReset(resetN, 1'b1, "expired before swap");
			nextCycle();
		end
		cpuAs = 1'b0;
		cpuWr = 1'b0;
		lineSwap = 1'b1;
		nextCycle();
		lineSwap = 1'b0;
		lag = 0;
		@(negedge CLK_1MB);
		while (resetN !== 1'b0 && lag < 4)
		begin
			lag++;
			@(negedge CLK_1MB);
		end
		if (resetN !== 1'b0)
		begin
			errCount++;
			$display("Timeout waiting for resetN pulse after lineSwap");
		end
		else
		begin
			if (lag != 0)
			begin
				errCount++;
				$display("Reset pulse started %0d cycles late after the line swap", lag);
			end
			for (i = 0; i < `B1_WD_PULSE; i++)
			begin
				checkReset(resetN, 1'b0, "pulse");
				@(negedge CLK_1MB);
			end
			checkReset(resetN, 1'b1, "after pulse");
		end
	endtask

	initial
	begin
		seed = 32'h5cf3e439;
		errCount = 0;
		checkCount = 0;
		{pck1, pck2, ldX, sprWe, lineSwap, chbl, cpuAs, cpuWr} = '0;
		pbus = '0;
		gad = '0;
		fixd = '0;
		cpuAddr = '0;
		fixPalModel = 4'h0;
		clearModel();
		applyReset();
		renderTest();
		transparencyTest();
		fixTest();
		blankCpuTest();
		watchdogTest();
		$display("Summary: %0d checks, %0d errors, %0d assertion failures",
			checkCount, errCount, i_dut.i_assert.failCount);
		if (errCount == 0 && i_dut.i_assert.failCount == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

//--- dv/neoB1_assertions.sv
`timescale 1ns/1ps
`include "b1_params.svh"

// Concurrent checks on the top level
module neoB1Assertions import b1Pkg::*;
(
	input logic        CLK_1MB,
	input logic        arstN,
	input logic        resetN,
	input palAddr_t    pa,
	input logic        chblDly,
	input logic        cpuAs,
	input logic [23:1] cpuAddr,
	input logic        lineSwap,
	input wdState_t    wdState
);

	int   lowRun;         // Consecutive low samples of resetN
	int   failCount = 0;  // Failed assertions so far
	logic cpuPal;

	assign cpuPal = cpuAs && (cpuAddr[23:22] == `B1_CPU_PAL_HI);

	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
			lowRun <= 0;
		else if (!resetN)
			lowRun <= lowRun + 1;
		else
			lowRun <= 0;
	end

	// Pulse neither short nor long
	pulseShort: assert property (@(posedge CLK_1MB) disable iff (!arstN)
		$rose(resetN) |-> lowRun == `B1_WD_PULSE)
		else
		begin
			failCount++;
			$error("resetN low for %0d cycles", lowRun);
		end
	pulseLong: assert property (@(posedge CLK_1MB) disable iff (!arstN)
		!resetN |-> lowRun < `B1_WD_PULSE)
		else
		begin
			failCount++;
			$error("resetN held low too long");
		end

	blankZero: assert property (@(posedge CLK_1MB) disable iff (!arstN)
		chblDly |=> (pa == '0) || cpuPal)
		else
		begin
			failCount++;
			$error("pa not colour 0 after blanking");
		end

	// Only a line swap releases the expired watchdog
	holdWait: assert property (@(posedge CLK_1MB) disable iff (!arstN)
		(wdState == wdWaitSwap) && !lineSwap |=> wdState == wdWaitSwap)
		else
		begin
			failCount++;
			$error("watchdog left wait state without lineSwap");
		end

endmodule

bind neoB1 neoB1Assertions i_assert (.CLK_1MB, .arstN, .resetN, .pa, .chblDly, .cpuAs,
	.cpuAddr, .lineSwap, .wdState(i_wd.state));

//--- files.f
+incdir+verilog
verilog/b1Pkg.sv
verilog/paletteLatch.sv
verilog/lineBuffer.sv
verilog/pixelMixer.sv
verilog/watchdog.sv
verilog/neoB1.sv
dv/neoB1_assertions.sv
dv/neoB1Tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing -Wno-fatal --top-module neoB1Tb -f files.f -o simNeoB1

out=$(./obj_dir/simNeoB1) || { echo "$out"; exit 1; }
echo "$out"

if echo "$out" | grep -qx "all tests passed"; then
	exit 0
fi
exit 1

//--- verilog/b1Pkg.sv
`include "b1_params.svh"

package b1Pkg;

	// Palette RAM address, palette number above colour index
	typedef struct packed
	{
		logic [`B1_PAL_W-1:0] pal;
		logic [`B1_COL_W-1:0] col;
	} palAddr_t;

	// Watchdog FSM
	typedef enum logic [1:0]
	{
		wdCount,     // Counting towards expiry
		wdWaitSwap,  // Expired, waiting for frame start
		wdPulse      // Holding system reset low
	} wdState_t;

endpackage

//--- verilog/b1_params.svh
`ifndef B1_PARAMS_SVH
`define B1_PARAMS_SVH

// Palette address split
`define B1_PAL_W      8          // Palette number bits
`define B1_COL_W      4          // Colour index bits
`define B1_FIX_PAL_W  4          // Fix palette bits on PBUS 19:16
`define B1_X_W        8          // Sprite X start width

// Line buffer geometry
`define B1_LB_AW      8
`define B1_LB_DEPTH   256        // Entries per bank
`define B1_BACKDROP   12'hFFF    // Last colour of last palette

// CPU palette window, address bits 23:22
`define B1_CPU_PAL_HI 2'b01

// Watchdog, kick at 0x300000 region (bits 21:17)
`define B1_WD_KICK_HI 5'b11000
`define B1_WD_LIMIT   128        // Cycles without kick before expiry
`define B1_WD_PULSE   8          // Reset pulse length
`define B1_WD_CW      8          // Shared counter width

`endif

//--- verilog/lineBuffer.sv
`timescale 1ns/1ps
`include "b1_params.svh"

// Double-banked sprite line buffer
// Render bank is written by sprite pixels, display bank is read and cleared
module lineBuffer import b1Pkg::*;
(
	input  logic                 CLK_1MB,
	input  logic                 arstN,
	input  logic                 ldX,       // Load write counter
	input  logic [`B1_X_W-1:0]   xStart,
	input  logic                 sprWe,     // One sprite pixel
	input  logic [`B1_COL_W-1:0] gad,       // Sprite pixel colour
	input  logic [`B1_PAL_W-1:0] sprPal,
	input  logic                 lineSwap,  // Exchange banks
	output palAddr_t             lbPix
);

	localparam int entries = 2 * `B1_LB_DEPTH;
	localparam palAddr_t backdrop = palAddr_t'(`B1_BACKDROP);

	palAddr_t                   mem [0:entries-1];  // Bank is the top index bit
	logic [entries-1:0]         entryValid;          // Cleared entry reads as backdrop
	logic                       dispBank;            // Bank being displayed
	logic [`B1_LB_AW-1:0]       wrCnt;
	logic [`B1_LB_AW-1:0]       readCnt;
	logic [`B1_LB_AW:0]         wrIdx;
	logic [`B1_LB_AW:0]         rdIdx;
	logic                       opaque;

	assign opaque = |gad;  // Colour 0 is transparent
	assign wrIdx = {~dispBank, wrCnt};
	assign rdIdx = {dispBank, readCnt};

	// Bank flag and address counters
	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
		begin
			dispBank <= 1'b0;
			wrCnt    <= '0;
			readCnt  <= '0;
		end
		else
		begin
			if (ldX)
				wrCnt <= xStart[`B1_LB_AW-1:0];
			else if (sprWe)
				wrCnt <= wrCnt + 1'b1;  // Advances on transparent pixels too

			if (lineSwap)
			begin
				dispBank <= ~dispBank;
				readCnt  <= '0;  // Pixel 0 is read on the next edge
			end
			else if (readCnt == `B1_LB_AW'(`B1_LB_DEPTH - 1))
				readCnt <= '0;
			else
				readCnt <= readCnt + 1'b1;
		end
	end

	// Pixel storage
	always_ff @(posedge CLK_1MB)
	begin
		if (sprWe && opaque)
			mem[wrIdx] <= '{pal: sprPal, col: gad};
	end

	// Valid bits and read register
	// Reading an entry clears it back to backdrop for the next line
	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
		begin
			entryValid <= '0;
			lbPix      <= backdrop;
		end
		else
		begin
			if (sprWe && opaque)
				entryValid[wrIdx] <= 1'b1;
			entryValid[rdIdx] <= 1'b0;  // Different bank from the write
			lbPix <= entryValid[rdIdx] ? mem[rdIdx] : backdrop;
		end
	end

endmodule

//--- verilog/neoB1.sv
`timescale 1ns/1ps
`include "b1_params.svh"

// Sprite line buffer and palette address block
module neoB1 import b1Pkg::*;
(
	input  logic                 CLK_1MB,
	input  logic                 arstN,
	input  logic [23:0]          pbus,
	input  logic                 pck1,
	input  logic                 pck2,
	input  logic                 ldX,
	input  logic                 sprWe,
	input  logic [`B1_COL_W-1:0] gad,
	input  logic                 lineSwap,
	input  logic [`B1_COL_W-1:0] fixd,
	input  logic                 chbl,
	input  logic                 cpuAs,
	input  logic [23:1]          cpuAddr,
	input  logic                 cpuWr,
	output palAddr_t             pa,
	output logic                 resetN
);

	logic [`B1_PAL_W-1:0]     sprPal;
	logic [`B1_X_W-1:0]       xStart;
	logic [`B1_FIX_PAL_W-1:0] fixPal;
	logic [`B1_COL_W-1:0]     fixdDly;
	logic                     chblDly;
	palAddr_t                 lbPix;

	paletteLatch i_latch (.CLK_1MB, .arstN, .pbus, .pck1, .pck2, .fixd, .chbl,
		.sprPal, .xStart, .fixPal, .fixdDly, .chblDly);

	lineBuffer i_lb (.CLK_1MB, .arstN, .ldX, .xStart, .sprWe, .gad, .sprPal,
		.lineSwap, .lbPix);

	pixelMixer i_mix (.CLK_1MB, .arstN, .lbPix, .fixdDly, .fixPal, .chblDly,
		.cpuAs, .cpuAddr, .pa);

	// Sits beside the video path
	watchdog i_wd (.CLK_1MB, .arstN, .cpuAs, .cpuWr, .cpuAddr, .lineSwap, .resetN);

endmodule

//--- verilog/paletteLatch.sv
`timescale 1ns/1ps
`include "b1_params.svh"

// Parameter bus capture and fix/blank alignment
module paletteLatch
(
	input  logic                     CLK_1MB,
	input  logic                     arstN,
	input  logic [23:0]              pbus,     // Shared bus from LSPC
	input  logic                     pck1,     // Sprite palette and X strobe
	input  logic                     pck2,     // Fix palette strobe
	input  logic [`B1_COL_W-1:0]     fixd,     // Fix pixel colour
	input  logic                     chbl,     // Blanking
	output logic [`B1_PAL_W-1:0]     sprPal,
	output logic [`B1_X_W-1:0]       xStart,
	output logic [`B1_FIX_PAL_W-1:0] fixPal,
	output logic [`B1_COL_W-1:0]     fixdDly,
	output logic                     chblDly
);

	// Sprite attributes, held until next PCK1
	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
		begin
			sprPal <= '0;
			xStart <= '0;
		end
		else if (pck1)
		begin
			sprPal <= pbus[23:16];
			xStart <= pbus[15:8];
		end
	end

	// Fix palette, held until next PCK2
	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
			fixPal <= '0;
		else if (pck2)
			fixPal <= pbus[19:16];
	end

	// One cycle delay matches the line buffer read register
	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
		begin
			fixdDly <= '0;
			chblDly <= 1'b0;
		end
		else
		begin
			fixdDly <= fixd;
			chblDly <= chbl;
		end
	end

endmodule

//--- verilog/pixelMixer.sv
`timescale 1ns/1ps
`include "b1_params.svh"

// Final priority mux onto the palette address bus
// CPU > blanking > opaque fix > sprite/backdrop
module pixelMixer import b1Pkg::*;
(
	input  logic                     CLK_1MB,
	input  logic                     arstN,
	input  palAddr_t                 lbPix,
	input  logic [`B1_COL_W-1:0]     fixdDly,
	input  logic [`B1_FIX_PAL_W-1:0] fixPal,
	input  logic                     chblDly,
	input  logic                     cpuAs,
	input  logic [23:1]              cpuAddr,
	output palAddr_t                 pa
);

	palAddr_t videoNext;
	palAddr_t videoReg;   // Registered video address
	logic     fixOpaque;
	logic     cpuPal;     // CPU is in palette space

	assign fixOpaque = |fixdDly;

	always_comb
	begin
		if (chblDly)
			videoNext = '0;  // Colour 0 of palette 0 while blanked
		else if (fixOpaque)
		begin
			videoNext.pal = {{(`B1_PAL_W - `B1_FIX_PAL_W){1'b0}}, fixPal};
			videoNext.col = fixdDly;
		end
		else
			videoNext = lbPix;
	end

	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
			videoReg <= '0;
		else
			videoReg <= videoNext;
	end

	// 0x400000-0x7FFFFF window
	assign cpuPal = cpuAs && (cpuAddr[23:22] == `B1_CPU_PAL_HI);

	// No latency on the CPU path
	assign pa = cpuPal ? palAddr_t'(cpuAddr[12:1]) : videoReg;

endmodule

//--- verilog/watchdog.sv
`timescale 1ns/1ps
`include "b1_params.svh"

// Watchdog with reset pulse aligned to frame start
module watchdog import b1Pkg::*;
(
	input  logic        CLK_1MB,
	input  logic        arstN,
	input  logic        cpuAs,
	input  logic        cpuWr,
	input  logic [23:1] cpuAddr,
	input  logic        lineSwap,  // Stands in for frame start
	output logic        resetN     // System reset, active low
);

	wdState_t              state;
	logic [`B1_WD_CW-1:0]  cnt;    // Timeout, then pulse length
	logic                  kick;

	assign kick = cpuAs && cpuWr && (cpuAddr[21:17] == `B1_WD_KICK_HI);

	always_ff @(posedge CLK_1MB or negedge arstN)
	begin
		if (!arstN)
		begin
			state <= wdCount;
			cnt   <= '0;
		end
		else
		begin
			case (state)
				wdCount:
				begin
					if (kick)
						cnt <= '0;
					else if (cnt == `B1_WD_CW'(`B1_WD_LIMIT - 1))
					begin
						state <= wdWaitSwap;  // Expired
						cnt   <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
				wdWaitSwap:
				begin
					if (lineSwap)  // Kicks no longer matter here
						state <= wdPulse;
				end
				wdPulse:
				begin
					if (cnt == `B1_WD_CW'(`B1_WD_PULSE - 1))
					begin
						state <= wdCount;
						cnt   <= '0;
					end
					else
						cnt <= cnt + 1'b1;
				end
				default:
				begin
					state <= wdCount;
					cnt   <= '0;
				end
			endcase
		end
	end

	assign resetN = (state != wdPulse);  // Decoded from the state register

endmodule
